// ==== source/soc_bus_pkg.sv ====
// Shared bus types, slave numbering and address decode table, imported by every fabric module
package soc_bus_pkg;

  // Bus word and address formats
  typedef logic [15:0] data_t;
  // Bit 19 is the IO flag, bits 18..0 carry word address bits 19..1
  typedef logic [19:0] addr_t;
  typedef logic [1:0]  sel_t;

  // Slave numbering
  localparam int NUM_SLAVES = 9;
  typedef logic [3:0] slave_idx_t;

  // Internal default slave sits just past the external ones
  localparam slave_idx_t DEFAULT_SLAVE = 4'd9;
  localparam data_t      DEFAULT_DATA  = 16'hFFFF;

  // Interrupt controller
  localparam int    NUM_IRQ         = 8;
  localparam data_t IRQ_VECTOR_BASE = 16'h0008;

  // Reset hold counter width
  localparam int DEBOUNCE_BITS_DEFAULT = 17;

  // One decode row
  typedef struct packed {
    slave_idx_t slave;
    addr_t      adr_match;
    addr_t      adr_mask;
  } decode_entry_t;

  localparam int DECODE_ENTRIES = 13;

  // Build a row from byte addresses; the IO flag always takes part in the compare
  function automatic decode_entry_t make_entry(input slave_idx_t slave,
                                               input logic       io,
                                               input logic [19:0] base,
                                               input logic [19:0] mask);
    decode_entry_t entry;
    entry.slave     = slave;
    entry.adr_match = {io, base[19:1]};
    entry.adr_mask  = {1'b1, mask[19:1]};
    return entry;
  endfunction

  // Searched in order, first hit wins
  localparam decode_entry_t DECODE_TABLE [DECODE_ENTRIES] = '{
    make_entry(4'd0, 1'b0, 20'hF0000, 20'hF0000),  // Boot ROM
    make_entry(4'd0, 1'b0, 20'hC0000, 20'hF0000),  // Option ROM
    make_entry(4'd0, 1'b1, 20'h0E000, 20'h0FE00),
    make_entry(4'd1, 1'b0, 20'hA0000, 20'hE0000),  // Video memory
    make_entry(4'd1, 1'b1, 20'h003C0, 20'h0FFE0),
    make_entry(4'd2, 1'b1, 20'h003F8, 20'h0FFF8),
    // Bit 1 masked in, so 60 and 64 hit but 62 does not
    make_entry(4'd3, 1'b1, 20'h00060, 20'h0FFFA),
    make_entry(4'd4, 1'b1, 20'h00100, 20'h0FFFE),
    make_entry(4'd5, 1'b1, 20'h0F100, 20'h0FFFC),
    make_entry(4'd6, 1'b1, 20'h0F200, 20'h0FFF0),
    make_entry(4'd7, 1'b1, 20'h00040, 20'h0FFFC),
    make_entry(4'd8, 1'b1, 20'h0F300, 20'h0FF00),
    // Catch-all for memory
    make_entry(4'd8, 1'b0, 20'h00000, 20'h00000)
  };

endpackage

// ==== source/reset_debounce.sv ====
// Power-on reset generator that holds the internal bus reset after the raw reset releases
`timescale 1ns/1ps

module reset_debounce import soc_bus_pkg::*; #(
  parameter int DEBOUNCE_BITS = DEBOUNCE_BITS_DEFAULT
) (
  input  logic clk,
  input  logic rst_lck,
  output logic rst_sys_no
);

  logic [DEBOUNCE_BITS-1:0] hold_cnt;
  logic                     cnt_done;

  assign cnt_done = (hold_cnt == '0);

  // Reload while raw reset is low, then run down to zero
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      hold_cnt <= '1;
    end else if (!cnt_done) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // Release one cycle after the count hits zero
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      rst_sys_no <= 1'b0;
    end else begin
      rst_sys_no <= cnt_done;
    end
  end

  // A raw reset pulse must always reach the fabric
  a_reset_follows: assert property (
    @(posedge clk) !rst_lck |=> !rst_sys_no
  ) else $error("internal reset not asserted after raw reset");

endmodule

// ==== source/addr_decoder.sv ====
// Address decoder that maps the master address onto one slave using the shared decode table
`timescale 1ns/1ps

module addr_decoder import soc_bus_pkg::*; (
  input  addr_t      m_adr_i,
  input  logic       m_stb_i,
  input  logic       m_cyc_i,
  output slave_idx_t sel_idx_o
);

  logic [DECODE_ENTRIES-1:0] row_hit;

  // Compare every row in parallel
  always_comb begin
    for (int r = 0; r < DECODE_ENTRIES; r++) begin
      row_hit[r] = ((m_adr_i & DECODE_TABLE[r].adr_mask) == DECODE_TABLE[r].adr_match);
    end
  end

  // Walk from the last row up so the earliest matching row wins
  always_comb begin
    sel_idx_o = DEFAULT_SLAVE;
    for (int r = DECODE_ENTRIES - 1; r >= 0; r--) begin
      if (row_hit[r]) begin
        sel_idx_o = DECODE_TABLE[r].slave;
      end
    end
  end

  // Selection has to stay inside the slave range while a cycle runs
  always_comb begin
    if (m_stb_i && m_cyc_i) begin
      a_sel_range: assert (sel_idx_o <= DEFAULT_SLAVE)
        else $error("decoder selected slave %0d", sel_idx_o);
    end
  end

endmodule

// ==== source/bus_switch.sv ====
// Bus switch that steers master strobes to the decoded slave and returns its ack and read data
`timescale 1ns/1ps

module bus_switch import soc_bus_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_sys_ni,
  input  slave_idx_t                   sel_idx_i,

  // Master side
  input  addr_t                        m_adr_i,
  input  data_t                        m_dat_i,
  input  sel_t                         m_sel_i,
  input  logic                         m_we_i,
  input  logic                         m_cyc_i,
  input  logic                         m_stb_i,

  // Slave side, shared fields
  output addr_t                        s_adr_o,
  output data_t                        s_dat_o,
  output sel_t                         s_sel_o,
  output logic                         s_we_o,

  // Slave side, per slave
  output logic  [NUM_SLAVES-1:0]       s_stb_o,
  output logic  [NUM_SLAVES-1:0]       s_cyc_o,
  input  data_t [NUM_SLAVES-1:0]       s_dat_i,
  input  logic  [NUM_SLAVES-1:0]       s_ack_i,

  // Return path
  output data_t                        bus_dat_o,
  output logic                         m_ack_o
);

  logic [NUM_SLAVES-1:0] slv_hit;
  logic                  def_hit;
  logic                  cyc_en;
  logic                  stb_en;
  logic                  slv_ack;

  // Shared fields go to every slave unchanged
  assign s_adr_o = m_adr_i;
  assign s_dat_o = m_dat_i;
  assign s_sel_o = m_sel_i;
  assign s_we_o  = m_we_i;

  // No bus activity while the internal reset holds
  assign cyc_en = rst_sys_ni & m_cyc_i;
  assign stb_en = cyc_en & m_stb_i;

  for (genvar g = 0; g < NUM_SLAVES; g++) begin : g_slave
    assign slv_hit[g] = (sel_idx_i == slave_idx_t'(g));
  end

  assign def_hit = (sel_idx_i == DEFAULT_SLAVE);

  assign s_cyc_o = slv_hit & {NUM_SLAVES{cyc_en}};
  assign s_stb_o = slv_hit & {NUM_SLAVES{stb_en}};

  // Return mux; the default slave answers FFFF and acks its own strobe
  always_comb begin
    slv_ack   = def_hit;
    bus_dat_o = DEFAULT_DATA;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (slv_hit[i]) begin
        slv_ack   = s_ack_i[i];
        bus_dat_o = s_dat_i[i];
      end
    end
  end

  assign m_ack_o = stb_en & slv_ack;

  // At most one slave strobed at a time
  a_stb_onehot: assert property (
    @(posedge clk) $onehot0(s_stb_o)
  ) else $error("more than one slave strobe active: %b", s_stb_o);

endmodule

// ==== source/int_ctrl.sv ====
// Priority interrupt controller that also supplies the final read data word to the master
`timescale 1ns/1ps

module int_ctrl import soc_bus_pkg::*; (
  input  logic               clk,
  input  logic               rst_sys_ni,
  input  logic [NUM_IRQ-1:0] irq_i,
  input  logic               inta_i,
  input  data_t              bus_dat_i,
  output logic               intr_o,
  output data_t              m_dat_o
);

  localparam int IID_W = $clog2(NUM_IRQ);

  logic [NUM_IRQ-1:0] irq_q;
  logic [NUM_IRQ-1:0] irq_rise;
  logic [NUM_IRQ-1:0] pending;
  logic [NUM_IRQ-1:0] clr_mask;
  logic [IID_W-1:0]   iid;
  logic [IID_W-1:0]   iid_q;
  logic               inta_q;
  logic               inta_fall;

  assign irq_rise  = irq_i & ~irq_q;
  assign inta_fall = inta_q & ~inta_i;

  // Lowest-numbered pending line has priority
  always_comb begin
    iid = '0;
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (pending[i]) begin
        iid = IID_W'(i);
      end
    end
  end

  // Served line is retired when the acknowledge drops
  always_comb begin
    clr_mask = '0;
    if (inta_fall) begin
      clr_mask[iid_q] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_sys_ni) begin
      irq_q   <= '0;
      pending <= '0;
      inta_q  <= 1'b0;
      iid_q   <= '0;
    end else begin
      irq_q   <= irq_i;
      pending <= (pending | irq_rise) & ~clr_mask;
      inta_q  <= inta_i;
      // Keep tracking the ID for as long as the CPU acknowledges
      if (inta_i) begin
        iid_q <= iid;
      end
    end
  end

  assign intr_o = |pending;

  // Vector word replaces bus data during an acknowledge
  assign m_dat_o = inta_i ? data_t'(IRQ_VECTOR_BASE + data_t'(iid)) : bus_dat_i;

  // The CPU only acknowledges a request it has seen
  a_inta_needs_intr: assert property (
    @(posedge clk) disable iff (!rst_sys_ni) $rose(inta_i) |-> intr_o
  ) else $error("interrupt acknowledge without a pending request");

endmodule

// ==== source/soc_bus_top.sv ====
// Top level of the system bus fabric, joining reset, decode, switch and interrupt stages
`timescale 1ns/1ps

module soc_bus_top import soc_bus_pkg::*; #(
  parameter int DEBOUNCE_BITS = DEBOUNCE_BITS_DEFAULT
) (
  input  logic                   clk,
  input  logic                   rst_lck,

  // CPU master
  input  addr_t                  m_adr_i,
  input  data_t                  m_dat_i,
  input  sel_t                   m_sel_i,
  input  logic                   m_we_i,
  input  logic                   m_cyc_i,
  input  logic                   m_stb_i,
  input  logic                   inta_i,
  output data_t                  m_dat_o,
  output logic                   m_ack_o,
  output logic                   intr_o,

  // External slaves
  output addr_t                  s_adr_o,
  output data_t                  s_dat_o,
  output sel_t                   s_sel_o,
  output logic                   s_we_o,
  output logic  [NUM_SLAVES-1:0] s_stb_o,
  output logic  [NUM_SLAVES-1:0] s_cyc_o,
  input  data_t [NUM_SLAVES-1:0] s_dat_i,
  input  logic  [NUM_SLAVES-1:0] s_ack_i,

  // Interrupt request levels
  input  logic  [NUM_IRQ-1:0]    irq_i
);

  logic       rst_sys_n;
  slave_idx_t sel_idx;
  data_t      bus_dat;

  reset_debounce #(
    .DEBOUNCE_BITS (DEBOUNCE_BITS)
  ) i_reset_debounce (
    .clk        (clk),
    .rst_lck    (rst_lck),
    .rst_sys_no (rst_sys_n)
  );

  addr_decoder i_addr_decoder (
    .m_adr_i   (m_adr_i),
    .m_stb_i   (m_stb_i),
    .m_cyc_i   (m_cyc_i),
    .sel_idx_o (sel_idx)
  );

  bus_switch i_bus_switch (
    .clk        (clk),
    .rst_sys_ni (rst_sys_n),
    .sel_idx_i  (sel_idx),
    .m_adr_i    (m_adr_i),
    .m_dat_i    (m_dat_i),
    .m_sel_i    (m_sel_i),
    .m_we_i     (m_we_i),
    .m_cyc_i    (m_cyc_i),
    .m_stb_i    (m_stb_i),
    .s_adr_o    (s_adr_o),
    .s_dat_o    (s_dat_o),
    .s_sel_o    (s_sel_o),
    .s_we_o     (s_we_o),
    .s_stb_o    (s_stb_o),
    .s_cyc_o    (s_cyc_o),
    .s_dat_i    (s_dat_i),
    .s_ack_i    (s_ack_i),
    .bus_dat_o  (bus_dat),
    .m_ack_o    (m_ack_o)
  );

  // Read data passes through here so the vector can take its place
  int_ctrl i_int_ctrl (
    .clk        (clk),
    .rst_sys_ni (rst_sys_n),
    .irq_i      (irq_i),
    .inta_i     (inta_i),
    .bus_dat_i  (bus_dat),
    .intr_o     (intr_o),
    .m_dat_o    (m_dat_o)
  );

endmodule

// ==== sim/tb_soc_bus.sv ====
// Self-checking testbench for the bus fabric, replays the transactions listed in sim/soc_bus_stim.txt
`timescale 1ns/1ps

module tb_soc_bus import soc_bus_pkg::*;;

  localparam int DEBOUNCE    = 4;
  localparam int HOLD_CYCLES = 1 << DEBOUNCE;
  localparam int WAIT_LIMIT  = 40;

  logic                  clk;
  logic                  rst_lck;
  addr_t                 m_adr_i;
  data_t                 m_dat_i;
  sel_t                  m_sel_i;
  logic                  m_we_i;
  logic                  m_cyc_i;
  logic                  m_stb_i;
  logic                  inta_i;
  data_t                 m_dat_o;
  logic                  m_ack_o;
  logic                  intr_o;
  addr_t                 s_adr_o;
  data_t                 s_dat_o;
  sel_t                  s_sel_o;
  logic                  s_we_o;
  logic [NUM_SLAVES-1:0] s_stb_o;
  logic [NUM_SLAVES-1:0] s_cyc_o;
  data_t [NUM_SLAVES-1:0] s_dat_i;
  logic [NUM_SLAVES-1:0] s_ack_i;
  logic [NUM_IRQ-1:0]    irq_i;

  // Cycles left before the strobed slave acknowledges
  logic [3:0]  ack_wait;
  logic [31:0] lfsr_state = 32'h0c79cc81;
  logic [19:0] stim_mem [0:511];
  int          test_errs;
  int          test_count;
  int          fail_count;

  soc_bus_top #(
    .DEBOUNCE_BITS (DEBOUNCE)
  ) i_dut (
    .clk     (clk),
    .rst_lck (rst_lck),
    .m_adr_i (m_adr_i),
    .m_dat_i (m_dat_i),
    .m_sel_i (m_sel_i),
    .m_we_i  (m_we_i),
    .m_cyc_i (m_cyc_i),
    .m_stb_i (m_stb_i),
    .inta_i  (inta_i),
    .m_dat_o (m_dat_o),
    .m_ack_o (m_ack_o),
    .intr_o  (intr_o),
    .s_adr_o (s_adr_o),
    .s_dat_o (s_dat_o),
    .s_sel_o (s_sel_o),
    .s_we_o  (s_we_o),
    .s_stb_o (s_stb_o),
    .s_cyc_o (s_cyc_o),
    .s_dat_i (s_dat_i),
    .s_ack_i (s_ack_i),
    .irq_i   (irq_i)
  );

  // Slave n answers A000 plus n
  for (genvar n = 0; n < NUM_SLAVES; n++) begin : g_slave_model
    assign s_dat_i[n] = 16'hA000 + 16'(n);
  end

  assign s_ack_i = s_stb_o & {NUM_SLAVES{ack_wait == 4'd0}};

  always #5 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_bits(input int count, output logic [3:0] value);
    value = '0;
    for (int b = 0; b < count; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[2:0], lfsr_state[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("error %s: got %h, expected %h", name, got, expected);
    test_errs++;
  endtask

  task automatic close_test(input string what);
    test_count++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", test_count, what);
    end else begin
      fail_count++;
      $display("test %0d %s: failed with %0d errors", test_count, what, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic release_bus();
    @(posedge clk);
    #1;
    m_cyc_i  = 1'b0;
    m_stb_i  = 1'b0;
    m_we_i   = 1'b0;
    ack_wait = 4'd0;
  endtask

  // Unmapped IO read at byte address 0200, issued as the raw reset releases
  task automatic check_reset_hold();
    int waited;
    repeat (4) @(posedge clk);
    #1;
    rst_lck = 1'b1;
    m_adr_i = {1'b1, 19'h00100};
    m_cyc_i = 1'b1;
    m_stb_i = 1'b1;
    waited  = 0;
    @(negedge clk);
    while (!m_ack_o && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!m_ack_o) begin
      $display("default slave read was never acknowledged after reset");
      test_errs++;
    end
    if (m_ack_o && waited < HOLD_CYCLES) begin
      $display("read acknowledged after %0d cycles while internal reset should hold", waited);
      test_errs++;
    end
    if (m_dat_o !== 16'hFFFF) begin
      report_mismatch("m_dat_o", 32'(m_dat_o), 32'h0000FFFF);
    end
    release_bus();
    close_test("reset hold");
  endtask

  task automatic run_transfer(input logic [19:0] op, input logic [19:0] io,
                              input logic [19:0] addr, input logic [19:0] wdata,
                              input logic [19:0] exp_slv, input logic [19:0] exp_dat);
    logic [3:0]            dly;
    logic [3:0]            sel_bits;
    logic [NUM_SLAVES-1:0] exp_stb;
    addr_t                 adr;
    int                    exp_wait;
    int                    waited;
    draw_bits(2, dly);
    draw_bits(2, sel_bits);
    adr      = {io[0], addr[19:1]};
    exp_stb  = '0;
    exp_wait = 0;
    if (exp_slv[3:0] != 4'd9) begin
      exp_stb[exp_slv[3:0]] = 1'b1;
      exp_wait              = int'(dly);
    end
    @(posedge clk);
    #1;
    m_adr_i  = adr;
    m_dat_i  = wdata[15:0];
    m_sel_i  = sel_bits[1:0];
    m_we_i   = (op == 20'd1);
    m_cyc_i  = 1'b1;
    m_stb_i  = 1'b1;
    ack_wait = dly;
    @(negedge clk);
    if (s_stb_o !== exp_stb) begin
      report_mismatch("s_stb_o", 32'(s_stb_o), 32'(exp_stb));
    end
    if (s_cyc_o !== exp_stb) begin
      report_mismatch("s_cyc_o", 32'(s_cyc_o), 32'(exp_stb));
    end
    if (s_adr_o !== adr) begin
      report_mismatch("s_adr_o", 32'(s_adr_o), 32'(adr));
    end
    if (s_dat_o !== wdata[15:0]) begin
      report_mismatch("s_dat_o", 32'(s_dat_o), 32'(wdata[15:0]));
    end
    if (s_sel_o !== sel_bits[1:0] || s_we_o !== (op == 20'd1)) begin
      report_mismatch("s_sel_o/s_we_o", 32'({s_sel_o, s_we_o}),
                      32'({sel_bits[1:0], op == 20'd1}));
    end
    // Slave counts down its wait once per cycle
    waited = 0;
    while (!m_ack_o && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      if (ack_wait != 4'd0) begin
        ack_wait = ack_wait - 4'd1;
      end
      @(negedge clk);
      waited++;
    end
    if (!m_ack_o) begin
      $display("transfer to address %h was never acknowledged", adr);
      test_errs++;
    end else if (waited != exp_wait) begin
      report_mismatch("m_ack_o delay", 32'(waited), 32'(exp_wait));
    end
    if (op == 20'd0 && m_dat_o !== exp_dat[15:0]) begin
      report_mismatch("m_dat_o", 32'(m_dat_o), 32'(exp_dat[15:0]));
    end
    release_bus();
  endtask

  task automatic serve_interrupt(input logic [19:0] mask, input logic [19:0] exp_intr,
                                 input logic [19:0] exp_vec);
    int waited;
    @(posedge clk);
    #1;
    irq_i = mask[7:0];
    @(posedge clk);
    #1;
    irq_i  = '0;
    waited = 0;
    @(negedge clk);
    while (!intr_o && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!intr_o) begin
      $display("intr_o never rose for the pending requests");
      test_errs++;
    end else begin
      @(posedge clk);
      #1;
      inta_i = 1'b1;
      @(negedge clk);
      if (m_dat_o !== exp_vec[15:0]) begin
        report_mismatch("m_dat_o", 32'(m_dat_o), 32'(exp_vec[15:0]));
      end
      @(posedge clk);
      #1;
      inta_i = 1'b0;
      // Served bit drops one cycle after the acknowledge ends
      @(posedge clk);
      @(negedge clk);
      if (intr_o !== exp_intr[0]) begin
        report_mismatch("intr_o", 32'(intr_o), 32'(exp_intr[0]));
      end
    end
  endtask

  initial begin
    logic [8:0] pos;
    clk        = 1'b0;
    rst_lck    = 1'b0;
    m_adr_i    = '0;
    m_dat_i    = '0;
    m_sel_i    = '0;
    m_we_i     = 1'b0;
    m_cyc_i    = 1'b0;
    m_stb_i    = 1'b0;
    inta_i     = 1'b0;
    irq_i      = '0;
    ack_wait   = 4'd0;
    test_errs  = 0;
    test_count = 0;
    fail_count = 0;
    $readmemh("sim/soc_bus_stim.txt", stim_mem);
    check_reset_hold();
    // Six fields per line, op F ends the list
    pos = '0;
    while (stim_mem[pos] != 20'h0000F && pos < 9'd504) begin
      if (stim_mem[pos] == 20'd2) begin
        serve_interrupt(stim_mem[pos + 9'd3], stim_mem[pos + 9'd4], stim_mem[pos + 9'd5]);
        close_test($sformatf("interrupt mask %h", stim_mem[pos + 9'd3]));
      end else begin
        run_transfer(stim_mem[pos], stim_mem[pos + 9'd1], stim_mem[pos + 9'd2],
                     stim_mem[pos + 9'd3], stim_mem[pos + 9'd4], stim_mem[pos + 9'd5]);
        close_test($sformatf("op %0h io %0h addr %h", stim_mem[pos], stim_mem[pos + 9'd1],
                             stim_mem[pos + 9'd2]));
      end
      pos = pos + 9'd6;
    end
    $display("%0d tests run, %0d passed, %0d failed", test_count,
             test_count - fail_count, fail_count);
    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sim/soc_bus_stim.txt ====
// op (0 read, 1 write, 2 interrupt, F end)  io  byte address  wdata or irq mask
// expected slave (9 default) or intr_o after acknowledge  expected read data or vector
0 0 F0000 0000 0 A000
1 0 C0000 1234 0 0000
0 0 CFFFE 0000 0 A000
0 0 A0000 0000 1 A001
1 0 BFFFE 5A5A 1 0000
0 1 0E000 0000 0 A000
0 1 0E1FE 0000 0 A000
0 1 003C0 0000 1 A001
1 1 003DE 00C3 1 0000
0 1 003F8 0000 2 A002
0 1 00060 0000 3 A003
1 1 00064 0041 3 0000
0 1 00062 0000 9 FFFF
0 1 00100 0000 4 A004
1 1 0F102 BEEF 5 0000
0 1 0F100 0000 5 A005
0 1 0F20E 0000 6 A006
0 1 00042 0000 7 A007
0 1 0F3FE 0000 8 A008
0 0 12344 0000 8 A008
1 0 00000 FACE 8 0000
0 1 00200 0000 9 FFFF
2 0 00000 0012 1 0009
2 0 00000 0000 0 000C
F 0 00000 0000 0 0000

// ==== vlog.f ====
source/soc_bus_pkg.sv
source/reset_debounce.sv
source/addr_decoder.sv
source/bus_switch.sv
source/int_ctrl.sv
source/soc_bus_top.sv
sim/tb_soc_bus.sv

// ==== Makefile ====
# Verilator build and run for the bus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_bus
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)
PASS    := *** PASSED ***

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS)'

clean:
	rm -rf $(OBJ_DIR)
